// ==== tb/programInput.txt ====
// Hex words in order: program length, register write count, store count, program words,
// then register writes as index value, then stores as address value
22 12 4
// Program, instruction 0 upward
28400006 2881FFF3 00C22000 01061004 01464008 018A100C 01C20210 02080114
2A400064 39920000 2A820001 3A920004 42D20000 03161000 43520004 3B520008
10440002 2B800001 2B800002 129A0001 2BC00009 30C20001 2BC00063 30460002
2C1E0001 1800001D 2C600005 08000020 2C800001 04E00090 27C00000 2C800002
3C52000C 08000021
// Register writes in program order, index value
01 00000006  02 FFFFFFF3  03 FFFFFFF9
04 FFFFFFF3  05 FFFFFFF1  06 FFFFFFF7
07 00000060  08 FFFFFFFC  09 00000064
0A 00000007  0B FFFFFFF7  0C FFFFFFFD
0D 00000007  0F 00000009  10 0000000A
1F 0000001A  13 00000014  11 0000000F
// Stores in program order, address value
00000064 FFFFFFF7  00000068 00000007
0000006C 00000007  00000070 0000000F

// ==== sources.f ====
verilog/cpuPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWriteStage.sv
verilog/processor.sv
tb/processorTb.sv

// ==== tb/processorTb.sv ====
// Testbench for the pipelined processor
// Instruction and data memory models around the DUT
// Loader for program words and expected results from tb/programInput.txt
// Register-write and store monitors with one compare task per result kind
`timescale 1ns/100ps

module processorTb;
    import cpuPkg::*;

    localparam int clockPeriod   = 100;
    localparam int driveDelay    = 5;
    localparam int dmemAddrBits  = 12;
    localparam int memWords      = 4096;
    localparam int fileSize      = 128;
    localparam int timeoutCycles = 500;
    localparam int drainCycles   = 20;

    logic                     clock;
    logic                     reset;
    logic [imemAddrWidth-1:0] imemAddress;
    logic [wordWidth-1:0]     imemData;
    logic [wordWidth-1:0]     dmemAddress;
    logic [wordWidth-1:0]     dmemWriteData;
    logic                     dmemWriteEnable;
    logic [wordWidth-1:0]     dmemReadData;
    logic                     regWriteEnable;
    logic [regIndexWidth-1:0] regWriteIndex;
    logic [wordWidth-1:0]     regWriteData;

    // Raw data file, then the two memories
    logic [wordWidth-1:0] fileWords [fileSize];
    logic [wordWidth-1:0] imem [memWords];
    logic [wordWidth-1:0] dmem [memWords];

    // Expected sequences in program order
    logic [regIndexWidth-1:0] expRegIndex [$];
    logic [wordWidth-1:0]     expRegValue [$];
    logic [wordWidth-1:0]     expStoreAddress [$];
    logic [wordWidth-1:0]     expStoreValue [$];
    int regsSeen;
    int storesSeen;
    int waitCycles;

    processor processor_inst (
        .clock           (clock),
        .reset           (reset),
        .imemAddress     (imemAddress),
        .imemData        (imemData),
        .dmemAddress     (dmemAddress),
        .dmemWriteData   (dmemWriteData),
        .dmemWriteEnable (dmemWriteEnable),
        .dmemReadData    (dmemReadData),
        .regWriteEnable  (regWriteEnable),
        .regWriteIndex   (regWriteIndex),
        .regWriteData    (regWriteData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    ////////////////////
    // Checks
    ////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkRegWrite(input logic [regIndexWidth-1:0] index,
                                 input logic [wordWidth-1:0] value);
        if (regsSeen >= expRegIndex.size())
            abortRun($sformatf("Unexpected register write r%0d = %h after the last expected one",
                               index, value));
        else if (index !== expRegIndex[regsSeen] || value !== expRegValue[regsSeen])
            abortRun($sformatf("FAILED at %0t: register write %0d is r%0d = %h, expected r%0d = %h",
                               $time, regsSeen, index, value,
                               expRegIndex[regsSeen], expRegValue[regsSeen]));
        else
            regsSeen++;
    endtask

    task automatic checkStore(input logic [wordWidth-1:0] address,
                              input logic [wordWidth-1:0] value);
        if (storesSeen >= expStoreAddress.size())
            abortRun($sformatf("Unexpected store of %h to %h after the last expected one",
                               value, address));
        else if (address !== expStoreAddress[storesSeen] || value !== expStoreValue[storesSeen])
            abortRun($sformatf("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                               $time, storesSeen, value, address,
                               expStoreValue[storesSeen], expStoreAddress[storesSeen]));
        else
            storesSeen++;
    endtask

    function automatic logic allChecked();
        return (regsSeen == expRegIndex.size()) && (storesSeen == expStoreAddress.size());
    endfunction

    // File layout: three counts, program words, index/value pairs, address/value pairs
    task automatic loadProgram();
        int progLength;
        int regCount;
        int storeCount;
        int pos;
        int a;
        $readmemh("tb/programInput.txt", fileWords);
        progLength = fileWords[0];
        regCount   = fileWords[1];
        storeCount = fileWords[2];
        if ($isunknown({fileWords[0], fileWords[1], fileWords[2]}) ||
            3 + progLength + 2 * (regCount + storeCount) > fileSize)
            abortRun("Could not read a valid program from tb/programInput.txt");
        else begin
            // Unused code words jump to themselves, data words carry their address
            for (a = 0; a < memWords; a++) begin
                imem[a] = {opJ, 27'(a)};
                dmem[a] = 32'hDA7A0000 | a;
            end
            for (a = 0; a < progLength; a++)
                imem[a] = fileWords[3 + a];
            pos = 3 + progLength;
            for (a = 0; a < regCount; a++) begin
                expRegIndex.push_back(fileWords[pos][regIndexWidth-1:0]);
                expRegValue.push_back(fileWords[pos + 1]);
                pos += 2;
            end
            for (a = 0; a < storeCount; a++) begin
                expStoreAddress.push_back(fileWords[pos]);
                expStoreValue.push_back(fileWords[pos + 1]);
                pos += 2;
            end
        end
    endtask

    ////////////////////
    // Memory models
    ////////////////////
    // Addresses only move at the edge, so a late drive matches a combinational read
    always @(posedge clock) begin
        #driveDelay;
        imemData     = imem[imemAddress];
        dmemReadData = dmem[dmemAddress[dmemAddrBits-1:0]];
    end

    // Writeback to r0 is the bubble, never a result
    always @(posedge clock) begin
        if (!reset) begin
            if (regWriteEnable && regWriteIndex != '0)
                checkRegWrite(regWriteIndex, regWriteData);
            if (dmemWriteEnable) begin
                checkStore(dmemAddress, dmemWriteData);
                dmem[dmemAddress[dmemAddrBits-1:0]] = dmemWriteData;
            end
        end
    end

    ////////////////////
    // Sequence
    ////////////////////
    initial begin
        reset        = 1'b1;
        imemData     = '0;
        dmemReadData = '0;
        regsSeen     = 0;
        storesSeen   = 0;
        waitCycles   = 0;
        loadProgram();
        repeat (3) @(posedge clock);
        #driveDelay;
        reset = 1'b0;
        // Counters move at the rising edge, so look at them on the falling one
        while (!allChecked() && waitCycles < timeoutCycles) begin
            @(negedge clock);
            waitCycles++;
        end
        if (!allChecked())
            abortRun($sformatf("Timed out after %0d cycles, %0d register writes and %0d stores seen",
                               waitCycles, regsSeen, storesSeen));
        else begin
            // Program now spins on its last jump, any write from here is extra
            repeat (drainCycles) @(negedge clock);
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog/processor.sv ====
// Processor top level
// Fetch, decode, execute and memory/writeback stages around the register file
// Instruction and data memory sit outside on the ports
`timescale 1ns/100ps

module processor (
    input  logic                             clock,
    input  logic                             reset,
    output logic [cpuPkg::imemAddrWidth-1:0] imemAddress,
    input  logic [cpuPkg::wordWidth-1:0]     imemData,
    output logic [cpuPkg::wordWidth-1:0]     dmemAddress,
    output logic [cpuPkg::wordWidth-1:0]     dmemWriteData,
    output logic                             dmemWriteEnable,
    input  logic [cpuPkg::wordWidth-1:0]     dmemReadData,
    output logic                             regWriteEnable,
    output logic [cpuPkg::regIndexWidth-1:0] regWriteIndex,
    output logic [cpuPkg::wordWidth-1:0]     regWriteData
);
    import cpuPkg::*;

    // Stage-to-stage wiring
    logic                     redirect, loadUseStall;
    logic [wordWidth-1:0]     redirectPc, fdPcPlus1, dxPcPlus1;
    instrWord                 fdInstr, dxInstr, xmInstr, mwInstr;
    logic [regIndexWidth-1:0] readIndexA, readIndexB, dxIndexB;
    logic [wordWidth-1:0]     readDataA, readDataB, dxDataA, dxDataB;
    logic [wordWidth-1:0]     xmStoreData, writeData;

    fetchStage fetchStage_inst (
        .clock (clock), .reset (reset),
        .redirect (redirect), .redirectPc (redirectPc), .loadUseStall (loadUseStall),
        .imemData (imemData), .imemAddress (imemAddress),
        .fdInstr (fdInstr), .fdPcPlus1 (fdPcPlus1)
    );

    decodeStage decodeStage_inst (
        .clock (clock), .reset (reset),
        .fdInstr (fdInstr), .fdPcPlus1 (fdPcPlus1),
        .readDataA (readDataA), .readDataB (readDataB), .redirect (redirect),
        .readIndexA (readIndexA), .readIndexB (readIndexB), .loadUseStall (loadUseStall),
        .dxInstr (dxInstr), .dxPcPlus1 (dxPcPlus1),
        .dxDataA (dxDataA), .dxDataB (dxDataB), .dxIndexB (dxIndexB)
    );

    // xmResult doubles as the data memory address
    executeStage executeStage_inst (
        .clock (clock), .reset (reset),
        .dxInstr (dxInstr), .dxPcPlus1 (dxPcPlus1),
        .dxDataA (dxDataA), .dxDataB (dxDataB), .dxIndexB (dxIndexB),
        .mwInstr (mwInstr), .writeData (writeData),
        .redirect (redirect), .redirectPc (redirectPc),
        .xmInstr (xmInstr), .xmResult (dmemAddress), .xmStoreData (xmStoreData)
    );

    regFile regFile_inst (
        .clock (clock), .reset (reset),
        .writeEnable (regWriteEnable), .writeIndex (regWriteIndex),
        .writeData (regWriteData),
        .readIndexA (readIndexA), .readIndexB (readIndexB),
        .readDataA (readDataA), .readDataB (readDataB)
    );

    memWriteStage memWriteStage_inst (
        .clock (clock), .reset (reset),
        .xmInstr (xmInstr), .xmResult (dmemAddress), .xmStoreData (xmStoreData),
        .dmemReadData (dmemReadData),
        .dmemWriteEnable (dmemWriteEnable), .dmemWriteData (dmemWriteData),
        .mwInstr (mwInstr), .writeData (writeData),
        .regWriteEnable (regWriteEnable), .regWriteIndex (regWriteIndex),
        .regWriteData (regWriteData)
    );

endmodule

// ==== verilog/memWriteStage.sv ====
// Memory and writeback stages
// Store enable and store-data bypass, memory/writeback latch
// Writeback index, data and enable selection
`timescale 1ns/100ps

module memWriteStage (
    input  logic                             clock,
    input  logic                             reset,
    input  cpuPkg::instrWord                 xmInstr,
    input  logic [cpuPkg::wordWidth-1:0]     xmResult,
    input  logic [cpuPkg::wordWidth-1:0]     xmStoreData,
    input  logic [cpuPkg::wordWidth-1:0]     dmemReadData,
    output logic                             dmemWriteEnable,
    output logic [cpuPkg::wordWidth-1:0]     dmemWriteData,
    output cpuPkg::instrWord                 mwInstr,
    output logic [cpuPkg::wordWidth-1:0]     writeData,
    output logic                             regWriteEnable,
    output logic [cpuPkg::regIndexWidth-1:0] regWriteIndex,
    output logic [cpuPkg::wordWidth-1:0]     regWriteData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] mwResult, mwMemData, wbData;
    logic [4:0]           mwOpcode;

    ////////////////////
    // Memory stage
    ////////////////////
    assign dmemWriteEnable = (xmInstr.r.opcode == opSw);

    // Store data produced by the instruction now in writeback, e.g. a lw just ahead
    assign dmemWriteData = (dmemWriteEnable && regWriteEnable && regWriteIndex != '0 &&
                            xmInstr.r.rd == regWriteIndex) ? wbData : xmStoreData;

    always_ff @(posedge clock) begin
        if (reset)
            mwInstr <= nopWord;
        else
            mwInstr <= xmInstr;
    end

    always_ff @(posedge clock) begin
        mwResult  <= xmResult;
        mwMemData <= dmemReadData;
    end

    ////////////////////
    // Writeback
    ////////////////////
    assign mwOpcode = mwInstr.r.opcode;

    assign regWriteEnable = (mwOpcode == opAlu) || (mwOpcode == opAddi) ||
                            (mwOpcode == opLw)  || (mwOpcode == opJal);
    // jal always links through r31
    assign regWriteIndex  = (mwOpcode == opJal) ? linkReg : mwInstr.r.rd;
    assign wbData         = (mwOpcode == opLw) ? mwMemData : mwResult;

    assign regWriteData = wbData;
    assign writeData    = wbData;

    // A store never becomes a register write one stage later
    assert property (@(posedge clock) disable iff (reset)
        dmemWriteEnable |=> !regWriteEnable);

endmodule

// ==== verilog/executeStage.sv ====
// Execute stage
// Operand bypassing from XM and MW, ALU operand and function selection
// Jump and branch resolution, execute/memory latch
`timescale 1ns/100ps

module executeStage (
    input  logic                             clock,
    input  logic                             reset,
    input  cpuPkg::instrWord                 dxInstr,
    input  logic [cpuPkg::wordWidth-1:0]     dxPcPlus1,
    input  logic [cpuPkg::wordWidth-1:0]     dxDataA,
    input  logic [cpuPkg::wordWidth-1:0]     dxDataB,
    input  logic [cpuPkg::regIndexWidth-1:0] dxIndexB,
    input  cpuPkg::instrWord                 mwInstr,
    input  logic [cpuPkg::wordWidth-1:0]     writeData,
    output logic                             redirect,
    output logic [cpuPkg::wordWidth-1:0]     redirectPc,
    output cpuPkg::instrWord                 xmInstr,
    output logic [cpuPkg::wordWidth-1:0]     xmResult,
    output logic [cpuPkg::wordWidth-1:0]     xmStoreData
);
    import cpuPkg::*;

    logic [4:0]           opcode;
    logic                 isImm, isBranch, isBlt, isJump, isJal, isJr, branchTaken;
    logic [wordWidth-1:0] operandA, operandB, immExt, target;
    logic [wordWidth-1:0] aluA, aluB, aluResult;
    logic [4:0]           aluFunct;
    logic                 notEqual, lessThan;

    // Producer writes a register unless it is a branch, jr or store
    function automatic logic writesReg(instrWord w);
        return !((w.r.opcode == opBne) || (w.r.opcode == opJr) ||
                 (w.r.opcode == opBlt) || (w.r.opcode == opSw));
    endfunction

    // Newest value first, XM before MW
    function automatic logic [wordWidth-1:0] bypass(
        logic [regIndexWidth-1:0] index,
        logic [wordWidth-1:0]     latched,
        instrWord                 xmWord,
        logic [wordWidth-1:0]     xmValue,
        instrWord                 mwWord,
        logic [wordWidth-1:0]     mwValue
    );
        if (index != '0 && writesReg(xmWord) && xmWord.r.rd == index)
            return xmValue;
        if (index != '0 && writesReg(mwWord) && mwWord.r.rd == index)
            return mwValue;
        return latched;
    endfunction

    assign opcode = dxInstr.r.opcode;
    assign isImm    = (opcode == opAddi) || (opcode == opLw) || (opcode == opSw);
    assign isBlt    = (opcode == opBlt);
    assign isBranch = (opcode == opBne) || isBlt;
    assign isJal    = (opcode == opJal);
    assign isJr     = (opcode == opJr);
    assign isJump   = (opcode == opJ) || isJal || isJr;

    ////////////////////
    // Operands
    ////////////////////
    assign operandA = bypass(dxInstr.r.rs, dxDataA, xmInstr, xmResult, mwInstr, writeData);
    assign operandB = bypass(dxIndexB, dxDataB, xmInstr, xmResult, mwInstr, writeData);

    assign immExt = {{(wordWidth-17){dxInstr.i.imm[16]}}, dxInstr.i.imm};
    assign target = {{(wordWidth-27){1'b0}}, dxInstr.ji.target};

    // blt compares rd against rs, so rd goes on the A side
    assign aluA = isBlt ? operandB : operandA;
    assign aluB = isBlt ? operandA : (isImm ? immExt : operandB);

    // Address and immediate math add, branches subtract
    assign aluFunct = isImm ? aluAdd : (isBranch ? aluSub : dxInstr.r.aluFn);

    alu alu_inst (
        .operandA (aluA),
        .operandB (aluB),
        .funct    (aluFunct),
        .shamt    (dxInstr.r.shamt),
        .result   (aluResult),
        .notEqual (notEqual),
        .lessThan (lessThan)
    );

    ////////////////////
    // Redirect
    ////////////////////
    assign branchTaken = ((opcode == opBne) && notEqual) || (isBlt && lessThan);
    assign redirect    = isJump || branchTaken;

    // jr goes through rd on port B
    always_comb begin
        if (isJr)
            redirectPc = operandB;
        else if (isJump)
            redirectPc = target;
        else
            redirectPc = dxPcPlus1 + immExt;
    end

    always_ff @(posedge clock) begin
        if (reset)
            xmInstr <= nopWord;
        else
            xmInstr <= dxInstr;
    end

    // jal hands its return address down as the result
    always_ff @(posedge clock) begin
        xmResult    <= isJal ? dxPcPlus1 : aluResult;
        xmStoreData <= operandB;
    end

    // Jump and taken branch exclusive, and the flush reaches decode/execute
    assert property (@(posedge clock) disable iff (reset)
        redirect |-> !(isJump && branchTaken) ##1 (dxInstr == nopWord));

endmodule

// ==== verilog/decodeStage.sv ====
// Decode stage
// Register read index selection, load-use hazard detection
// Decode/execute latch for instruction, PC+1 and operands
`timescale 1ns/100ps

module decodeStage (
    input  logic                             clock,
    input  logic                             reset,
    input  cpuPkg::instrWord                 fdInstr,
    input  logic [cpuPkg::wordWidth-1:0]     fdPcPlus1,
    input  logic [cpuPkg::wordWidth-1:0]     readDataA,
    input  logic [cpuPkg::wordWidth-1:0]     readDataB,
    input  logic                             redirect,
    output logic [cpuPkg::regIndexWidth-1:0] readIndexA,
    output logic [cpuPkg::regIndexWidth-1:0] readIndexB,
    output logic                             loadUseStall,
    output cpuPkg::instrWord                 dxInstr,
    output logic [cpuPkg::wordWidth-1:0]     dxPcPlus1,
    output logic [cpuPkg::wordWidth-1:0]     dxDataA,
    output logic [cpuPkg::wordWidth-1:0]     dxDataB,
    output logic [cpuPkg::regIndexWidth-1:0] dxIndexB
);
    import cpuPkg::*;

    logic usesRd;
    logic fdIsStore;
    logic dxIsLoad;

    assign fdIsStore = (fdInstr.r.opcode == opSw);
    assign dxIsLoad  = (dxInstr.r.opcode == opLw);

    // Branches, jr and sw read rd on port B
    assign usesRd = (fdInstr.r.opcode == opBne) ||
                    (fdInstr.r.opcode == opJr)  ||
                    (fdInstr.r.opcode == opBlt) ||
                    fdIsStore;

    assign readIndexA = fdInstr.r.rs;
    assign readIndexB = usesRd ? fdInstr.r.rd : fdInstr.r.rt;

    ////////////////////
    // Load-use hazard
    ////////////////////
    // Store data from a load is patched in the memory stage, so sw only checks rs
    assign loadUseStall = dxIsLoad &&
                          ((fdInstr.r.rs == dxInstr.r.rd) ||
                           ((fdInstr.r.rt == dxInstr.r.rd) && !fdIsStore));

    // Bubble on a flush or a load-use stall
    always_ff @(posedge clock) begin
        if (reset || redirect || loadUseStall)
            dxInstr <= nopWord;
        else
            dxInstr <= fdInstr;
    end

    // Operands and indices latch every cycle
    always_ff @(posedge clock) begin
        dxPcPlus1 <= fdPcPlus1;
        dxDataA   <= readDataA;
        dxDataB   <= readDataB;
        dxIndexB  <= readIndexB;
    end

    // Stalled instruction waits one more cycle in the fetch/decode latch
    assert property (@(posedge clock) disable iff (reset)
        loadUseStall |=> $stable(fdInstr));

endmodule

// ==== verilog/fetchStage.sv ====
// Fetch stage
// Program counter with redirect, stall hold and increment
// Fetch/decode latch for the instruction word and PC+1
`timescale 1ns/100ps

module fetchStage (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             redirect,
    input  logic [cpuPkg::wordWidth-1:0]     redirectPc,
    input  logic                             loadUseStall,
    input  cpuPkg::instrWord                 imemData,
    output logic [cpuPkg::imemAddrWidth-1:0] imemAddress,
    output cpuPkg::instrWord                 fdInstr,
    output logic [cpuPkg::wordWidth-1:0]     fdPcPlus1
);
    import cpuPkg::*;

    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] pcPlus1;
    logic [wordWidth-1:0] pcNext;

    assign pcPlus1     = pc + 32'd1;
    assign imemAddress = pc[imemAddrWidth-1:0];

    // Redirect wins over the load-use hold
    always_comb begin
        if (redirect)
            pcNext = redirectPc;
        else if (loadUseStall)
            pcNext = pc;
        else
            pcNext = pcPlus1;
    end

    always_ff @(posedge clock) begin
        if (reset)
            pc <= '0;
        else
            pc <= pcNext;
    end

    ////////////////////
    // Fetch/decode latch
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset || redirect)
            fdInstr <= nopWord;
        else if (!loadUseStall)
            fdInstr <= imemData;
    end

    // PC+1 travels along for jal and branch targets
    always_ff @(posedge clock) begin
        if (!loadUseStall)
            fdPcPlus1 <= pcPlus1;
    end

    // Instruction address stays defined once out of reset
    assert property (@(posedge clock) disable iff (reset) !$isunknown(imemAddress));

endmodule

// ==== verilog/regFile.sv ====
// Register file
// 32 words, two combinational read ports, one write port at the clock edge
`timescale 1ns/100ps

module regFile (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             writeEnable,
    input  logic [cpuPkg::regIndexWidth-1:0] writeIndex,
    input  logic [cpuPkg::wordWidth-1:0]     writeData,
    input  logic [cpuPkg::regIndexWidth-1:0] readIndexA,
    input  logic [cpuPkg::regIndexWidth-1:0] readIndexB,
    output logic [cpuPkg::wordWidth-1:0]     readDataA,
    output logic [cpuPkg::wordWidth-1:0]     readDataB
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [2**regIndexWidth];

    // r0 never written
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**regIndexWidth; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // r0 reads zero, a same-cycle writeback passes straight to decode
    assign readDataA = (readIndexA == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexA) ? writeData :
                       regs[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexB) ? writeData :
                       regs[readIndexB];

endmodule

// ==== verilog/alu.sv ====
// Arithmetic, logic and shift unit
// Add, sub, and, or, sll, sra with inequality and signed less-than flags
`timescale 1ns/100ps

module alu (
    input  logic [cpuPkg::wordWidth-1:0] operandA,
    input  logic [cpuPkg::wordWidth-1:0] operandB,
    input  logic [4:0]                   funct,
    input  logic [4:0]                   shamt,
    output logic [cpuPkg::wordWidth-1:0] result,
    output logic                         notEqual,
    output logic                         lessThan
);
    import cpuPkg::*;

    logic [wordWidth-1:0] difference;
    logic                 signA, signB;

    assign difference = operandA - operandB;
    assign signA      = operandA[wordWidth-1];
    assign signB      = operandB[wordWidth-1];

    // Flags come from the subtraction
    assign notEqual = (difference != '0);
    // Differing signs decide directly, otherwise the difference sign does
    assign lessThan = (signA != signB) ? signA : difference[wordWidth-1];

    always_comb begin
        case (funct)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = difference;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSll:  result = operandA << shamt;
            aluSra:  result = $signed(operandA) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

// ==== verilog/cpuPkg.sv ====
// Shared definitions for the pipelined processor
// Word and index widths, opcode values, ALU function codes
// Instruction word with its R, I and JI views, and the bubble word
package cpuPkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int wordWidth     = 32;
    localparam int regIndexWidth = 5;
    localparam int imemAddrWidth = 12;

    // Register written by jal
    localparam logic [regIndexWidth-1:0] linkReg = 5'd31;

    ////////////////////
    // Opcodes
    ////////////////////
    // Top five bits of every instruction
    localparam logic [4:0] opAlu  = 5'd0;
    localparam logic [4:0] opJ    = 5'd1;
    localparam logic [4:0] opBne  = 5'd2;
    localparam logic [4:0] opJal  = 5'd3;
    localparam logic [4:0] opJr   = 5'd4;
    localparam logic [4:0] opAddi = 5'd5;
    localparam logic [4:0] opBlt  = 5'd6;
    localparam logic [4:0] opSw   = 5'd7;
    localparam logic [4:0] opLw   = 5'd8;

    // ALU function field of R-type words
    localparam logic [4:0] aluAdd = 5'd0;
    localparam logic [4:0] aluSub = 5'd1;
    localparam logic [4:0] aluAnd = 5'd2;
    localparam logic [4:0] aluOr  = 5'd3;
    localparam logic [4:0] aluSll = 5'd4;
    localparam logic [4:0] aluSra = 5'd5;

    ////////////////////
    // Instruction word
    ////////////////////
    // Three views of one word, opcode always on top
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [4:0] rd;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] shamt;
            logic [4:0] aluFn;
            logic [1:0] spare;
        } r;
        struct packed {
            logic [4:0]  opcode;
            logic [4:0]  rd;
            logic [4:0]  rs;
            logic [16:0] imm;
        } i;
        struct packed {
            logic [4:0]  opcode;
            logic [26:0] target;
        } ji;
    } instrWord;

    // add r0, r0, r0 used as pipeline bubble
    localparam instrWord nopWord = '0;

endpackage
